/* verilog/xversat_pkg.sv */
`default_nettype none

package xversat_pkg;

   // word and host address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 9;

   // array shape
   localparam int N_STAGE   = 4;
   localparam int N_STAGE_W = 2;

   // 32 words per stage memory, lengths 1 to 32
   localparam int MEM_ADDR_W = 5;
   localparam int LEN_W      = 6;

   // address map
   localparam int RUN_BIT   = 8;
   localparam int STAGE_LSB = 6;
   localparam int CFG_BIT   = 5;

   // config register indices inside a stage
   localparam logic [CFG_BIT-1:0] CFG_OP     = 5'd0;
   localparam logic [CFG_BIT-1:0] CFG_STATUS = 5'd1;

   typedef logic [DATA_W-1:0] data_t;

   typedef logic [MEM_ADDR_W-1:0] idx_t;

   // sub is own minus flow
   typedef enum logic [2:0] {
      OP_ADD       = 3'd0,
      OP_SUB       = 3'd1,
      OP_AND       = 3'd2,
      OP_OR        = 3'd3,
      OP_XOR       = 3'd4,
      OP_PASS_OWN  = 3'd5,
      OP_PASS_FLOW = 3'd6
   } op_e;

endpackage

`default_nettype wire

/* verilog/xstage_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface xstage_bus_if
   import xversat_pkg::*;
   ();

   // host access, already steered to this stage
   logic                 sel;
   logic                 we;
   logic [STAGE_LSB-1:0] addr;
   data_t                wr_data;
   data_t                rd_data;

   // run broadcast and completion
   logic                 run;
   logic [LEN_W-1:0]     run_len;
   logic                 done;

   modport host (
      output sel, we, addr, wr_data, run, run_len,
      input  rd_data, done
   );

   modport stage (
      input  sel, we, addr, wr_data, run, run_len,
      output rd_data, done
   );

endinterface

`default_nettype wire

/* verilog/xalu_fu.sv */
`timescale 1ns/1ps
`default_nettype none

module xalu_fu
   import xversat_pkg::*;
   (
   input  wire op_e   op,
   input  wire data_t own,
   input  wire data_t flow,
   output data_t      result
   );

   always_comb begin
      case (op)
         OP_ADD: begin
            result = own + flow;
         end
         OP_SUB: begin
            result = own - flow;
         end
         OP_AND: begin
            result = own & flow;
         end
         OP_OR: begin
            result = own | flow;
         end
         OP_XOR: begin
            result = own ^ flow;
         end
         OP_PASS_OWN: begin
            result = own;
         end
         OP_PASS_FLOW: begin
            result = flow;
         end
         // unused code 7 lands here
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* verilog/xstage_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module xstage_mem
   import xversat_pkg::*;
   (
   input  wire logic  clk,
   input  wire logic  host_we,
   input  wire idx_t  host_idx,
   input  wire data_t host_data,
   input  wire logic  wb_we,
   input  wire idx_t  wb_idx,
   input  wire data_t wb_data,
   input  wire idx_t  rd_idx,
   output data_t      rd_data
   );

   data_t mem [2**MEM_ADDR_W];

   // writeback wins over the host
   always_ff @(posedge clk) begin
      if (wb_we) begin
         mem[wb_idx] <= wb_data;
      end else if (host_we) begin
         mem[host_idx] <= host_data;
      end
   end

   assign rd_data = mem[rd_idx];

   assert property (@(posedge clk)
      !((host_we === 1'b1) && (wb_we === 1'b1)));

endmodule

`default_nettype wire

/* verilog/xiter_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module xiter_counter
   import xversat_pkg::*;
   (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             start,
   input  wire logic             en,
   input  wire logic [LEN_W-1:0] run_len,
   output idx_t                  idx,
   output logic                  last
   );

   logic [LEN_W-1:0] len_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idx   <= '0;
         len_q <= '0;
      end else if (start) begin
         idx   <= '0;
         len_q <= run_len;
      end else if (en && !last) begin
         idx <= idx + 1'b1;
      end
   end

   // hold at the final index until the next start
   assign last = en & (LEN_W'(idx) == len_q - 1'b1);

   assert property (@(posedge clk) disable iff (!rst_n)
      en |-> (LEN_W'(idx) < len_q));

endmodule

`default_nettype wire

/* verilog/xrun_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module xrun_ctrl (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic run,
   input  wire logic last,
   output logic      busy,
   output logic      count_en,
   output logic      drain
   );

   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      RUN   = 2'd1,
      DRAIN = 2'd2
   } state_e;

   state_e state_q;
   state_e state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         // run strobes while busy are dropped
         IDLE: if (run) state_d = RUN;
         RUN: if (last) state_d = DRAIN;
         DRAIN: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign busy     = (state_q != IDLE);
   assign count_en = (state_q == RUN);
   assign drain    = (state_q == DRAIN);

   // counter must stay quiet outside a run
   assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == IDLE) |-> !last);

endmodule

`default_nettype wire

/* verilog/xstage.sv */
`timescale 1ns/1ps
`default_nettype none

module xstage
   import xversat_pkg::*;
   (
   input  wire logic   clk,
   input  wire logic   rst_n,
   xstage_bus_if.stage bus,
   input  wire data_t  flow_in,
   input  wire logic   flow_valid_in,
   output data_t       flow_out,
   output logic        flow_valid_out
   );

   logic  busy;
   logic  count_en;
   logic  last;
   logic  start;
   logic  done;
   logic  done_q;
   logic  cfg_sel;
   logic  mem_we;
   logic  op_we;
   logic  rd_valid_q;
   idx_t  run_idx;
   idx_t  host_idx;
   idx_t  rd_idx;
   idx_t  idx_q;
   data_t own_word;
   data_t own_q;
   data_t result;
   op_e   op_q;

   // local decode
   assign cfg_sel  = bus.addr[CFG_BIT];
   assign host_idx = bus.addr[MEM_ADDR_W-1:0];
   assign mem_we   = bus.sel & bus.we & ~cfg_sel & ~busy;
   assign op_we    = bus.sel & bus.we & cfg_sel & (bus.addr[CFG_BIT-1:0] == CFG_OP);

   assign start  = bus.run & ~busy;
   assign rd_idx = busy ? run_idx : host_idx;

   xrun_ctrl run_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (bus.run),
      .last     (last),
      .busy     (busy),
      .count_en (count_en),
      .drain    ()
   );

   xiter_counter iter_counter (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start),
      .en      (count_en),
      .run_len (bus.run_len),
      .idx     (run_idx),
      .last    (last)
   );

   xstage_mem mem (
      .clk       (clk),
      .host_we   (mem_we),
      .host_idx  (host_idx),
      .host_data (bus.wr_data),
      .wb_we     (rd_valid_q),
      .wb_idx    (idx_q),
      .wb_data   (result),
      .rd_idx    (rd_idx),
      .rd_data   (own_word)
   );

   xalu_fu alu (
      .op     (op_q),
      .own    (own_q),
      .flow   (flow_in),
      .result (result)
   );

   // read to writeback pipeline register
   always_ff @(posedge clk) begin
      own_q <= own_word;
      idx_q <= run_idx;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid_q <= 1'b0;
         done_q     <= 1'b1;
         op_q       <= OP_PASS_OWN;
      end else begin
         rd_valid_q <= count_en;
         done_q     <= ~busy;
         if (op_we) begin
            op_q <= op_e'(bus.wr_data[2:0]);
         end
      end
   end

   // falls with busy, rises one cycle after idle
   assign done     = done_q & ~busy;
   assign bus.done = done;

   assign flow_out       = own_q;
   assign flow_valid_out = rd_valid_q;

   always_comb begin
      bus.rd_data = '0;
      if (!cfg_sel) begin
         bus.rd_data = own_word;
      end else if (bus.addr[CFG_BIT-1:0] == CFG_OP) begin
         bus.rd_data = data_t'(op_q);
      end else if (bus.addr[CFG_BIT-1:0] == CFG_STATUS) begin
         bus.rd_data = data_t'(done);
      end
   end

   // neighbour must be in the same pipeline slot
   assert property (@(posedge clk) disable iff (!rst_n)
      flow_valid_in == rd_valid_q);

endmodule

`default_nettype wire

/* verilog/xversat.sv */
`timescale 1ns/1ps
`default_nettype none

module xversat
   import xversat_pkg::*;
   (
   input  wire logic              clk,
   input  wire logic              rst_n,

   // host strobes
   input  wire logic              valid,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic              we,
   input  wire data_t             rdata,
   output data_t                  wdata
   );

   xstage_bus_if bus [N_STAGE] ();

   // ring of flow words
   data_t flow [N_STAGE];
   logic  flow_valid [N_STAGE];

   data_t                stage_rd [N_STAGE];
   logic [N_STAGE-1:0]   done;
   logic                 run_sel;
   logic                 run;
   logic [N_STAGE_W-1:0] stage_idx;

   assign run_sel   = addr[RUN_BIT];
   assign stage_idx = addr[STAGE_LSB +: N_STAGE_W];

   // one write to the run region starts every stage
   assign run = valid & we & run_sel;

   for (genvar i = 0; i < N_STAGE; i++) begin : g_stage
      assign bus[i].sel     = valid & ~run_sel & (stage_idx == N_STAGE_W'(i));
      assign bus[i].we      = we;
      assign bus[i].addr    = addr[STAGE_LSB-1:0];
      assign bus[i].wr_data = rdata;
      assign bus[i].run     = run;
      assign bus[i].run_len = rdata[LEN_W-1:0];

      assign stage_rd[i] = bus[i].rd_data;
      assign done[i]     = bus[i].done;

      // stage i listens to stage i-1, stage 0 closes the ring
      xstage stage (
         .clk            (clk),
         .rst_n          (rst_n),
         .bus            (bus[i]),
         .flow_in        (flow[(i + N_STAGE - 1) % N_STAGE]),
         .flow_valid_in  (flow_valid[(i + N_STAGE - 1) % N_STAGE]),
         .flow_out       (flow[i]),
         .flow_valid_out (flow_valid[i])
      );
   end

   // read mux, zero when idle
   always_comb begin
      wdata = '0;
      if (valid) begin
         if (run_sel) begin
            wdata = data_t'(&done);
         end else begin
            wdata = stage_rd[stage_idx];
         end
      end
   end

endmodule

`default_nettype wire

/* bench/xversat_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xversat_tb
   import xversat_pkg::*;
   ();

   localparam int N_ROWS     = 4;
   localparam int N_WORDS    = 2**MEM_ADDR_W;
   localparam int POLL_LIMIT = 200;

   logic              clk;
   logic              rst_n;
   logic              valid;
   logic              we;
   logic [ADDR_W-1:0] addr;
   data_t             rdata;
   data_t             wdata;

   int errors;
   int timeouts;

   // memory image before the run and after it
   data_t orig [N_STAGE][N_WORDS];
   data_t exp_mem [N_STAGE][N_WORDS];

   // one row per run: op per stage, run length, fill offset
   op_e row_op [N_ROWS][N_STAGE];
   int  row_len [N_ROWS];
   int  row_off [N_ROWS];

   xversat xversat_i (
      .clk   (clk),
      .rst_n (rst_n),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .rdata (rdata),
      .wdata (wdata)
   );

   always #20 clk = ~clk;

   task automatic load_rows();
      row_op[0] = '{OP_ADD, OP_SUB, OP_AND, OP_OR};
      row_len[0] = 8;
      row_off[0] = 0;
      row_op[1] = '{OP_XOR, OP_PASS_OWN, OP_PASS_FLOW, OP_ADD};
      row_len[1] = 1;
      row_off[1] = 1;
      row_op[2] = '{OP_SUB, OP_XOR, OP_OR, OP_PASS_FLOW};
      row_len[2] = 32;
      row_off[2] = 2;
      row_op[3] = '{OP_AND, OP_ADD, OP_PASS_OWN, OP_SUB};
      row_len[3] = 17;
      row_off[3] = 3;
   endtask

   function automatic logic [ADDR_W-1:0] mem_addr(input int s, input int k);
      return ADDR_W'((s << STAGE_LSB) | k);
   endfunction

   function automatic logic [ADDR_W-1:0] cfg_addr(input int s, input int r);
      return ADDR_W'((s << STAGE_LSB) | (1 << CFG_BIT) | r);
   endfunction

   function automatic logic [ADDR_W-1:0] run_addr();
      return ADDR_W'(1 << RUN_BIT);
   endfunction

   // expected stage result, own word against neighbour word
   function automatic data_t model_result(input op_e op, input data_t own, input data_t flow);
      case (op)
         OP_ADD:       return own + flow;
         OP_SUB:       return own - flow;
         OP_AND:       return own & flow;
         OP_OR:        return own | flow;
         OP_XOR:       return own ^ flow;
         OP_PASS_OWN:  return own;
         OP_PASS_FLOW: return flow;
         default:      return '0;
      endcase
   endfunction

   // one access cycle, entered and left 2 ns after a rising edge
   task automatic bus_write(input logic [ADDR_W-1:0] a, input data_t d);
      valid = 1'b1;
      we    = 1'b1;
      addr  = a;
      rdata = d;
      @(posedge clk);
      #2;
      valid = 1'b0;
      we    = 1'b0;
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a, output data_t d);
      valid = 1'b1;
      we    = 1'b0;
      addr  = a;
      // read data settles well before the falling edge
      @(negedge clk);
      d = wdata;
      @(posedge clk);
      #2;
      valid = 1'b0;
   endtask

   task automatic report_error(input string what, input data_t got, input data_t want);
      errors++;
      $display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, want);
   endtask

   task automatic wait_done();
      data_t rd;
      int    polls;
      bit    ok;
      ok    = 1'b0;
      polls = 0;
      while (!ok && polls < POLL_LIMIT) begin
         bus_read(run_addr(), rd);
         polls++;
         if (rd[0]) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         timeouts++;
         $display("Timeout: the array did not report done within %0d polls", POLL_LIMIT);
      end
   endtask

   task automatic run_row(input int r);
      data_t rd;
      int    len;
      int    busy_stage;
      int    busy_idx;
      len = row_len[r];
      for (int j = 0; j < N_STAGE; j++) begin
         for (int k = 0; k < N_WORDS; k++) begin
            orig[j][k]    = $urandom() ^ (data_t'(row_off[r]) * 32'h0101_0101);
            exp_mem[j][k] = orig[j][k];
            bus_write(mem_addr(j, k), orig[j][k]);
         end
      end
      for (int j = 0; j < N_STAGE; j++) begin
         for (int k = 0; k < N_WORDS; k++) begin
            bus_read(mem_addr(j, k), rd);
            if (rd !== orig[j][k]) begin
               report_error($sformatf("fill stage %0d word %0d", j, k), rd, orig[j][k]);
            end
         end
         bus_write(cfg_addr(j, int'(CFG_OP)), data_t'(row_op[r][j]));
         bus_read(cfg_addr(j, int'(CFG_OP)), rd);
         if (rd !== data_t'(row_op[r][j])) begin
            report_error($sformatf("op register stage %0d", j), rd, data_t'(row_op[r][j]));
         end
      end
      // stage j sees stage j-1 on its flow input
      for (int j = 0; j < N_STAGE; j++) begin
         for (int k = 0; k < len; k++) begin
            exp_mem[j][k] = model_result(row_op[r][j], orig[j][k],
                                         orig[(j + N_STAGE - 1) % N_STAGE][k]);
         end
      end
      busy_stage = $urandom() % N_STAGE;
      busy_idx   = $urandom() % N_WORDS;
      bus_write(run_addr(), data_t'(len));
      // both of these land while the array is busy
      bus_write(run_addr(), data_t'(len % N_WORDS + 1));
      bus_write(mem_addr(busy_stage, busy_idx), $urandom());
      bus_read(run_addr(), rd);
      if (rd !== 32'd0) begin
         report_error("run status on first poll", rd, 32'd0);
      end
      wait_done();
      for (int j = 0; j < N_STAGE; j++) begin
         bus_read(cfg_addr(j, int'(CFG_STATUS)), rd);
         if (rd !== 32'd1) begin
            report_error($sformatf("status stage %0d after run", j), rd, 32'd1);
         end
      end
      for (int j = 0; j < N_STAGE; j++) begin
         for (int k = 0; k < N_WORDS; k++) begin
            bus_read(mem_addr(j, k), rd);
            if (rd !== exp_mem[j][k]) begin
               report_error($sformatf("row %0d stage %0d word %0d", r, j, k), rd,
                            exp_mem[j][k]);
            end
         end
      end
   endtask

   initial begin
      data_t rd;
      clk       = 1'b0;
      rst_n     = 1'b0;
      valid     = 1'b0;
      we        = 1'b0;
      addr      = '0;
      rdata     = '0;
      errors    = 0;
      timeouts  = 0;
      void'($urandom(32'h8af8));
      load_rows();
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // idle array reports done and pass-own ops
      bus_read(run_addr(), rd);
      if (rd !== 32'd1) begin
         report_error("run status after reset", rd, 32'd1);
      end
      for (int j = 0; j < N_STAGE; j++) begin
         bus_read(cfg_addr(j, int'(CFG_OP)), rd);
         if (rd !== data_t'(OP_PASS_OWN)) begin
            report_error($sformatf("reset op stage %0d", j), rd, data_t'(OP_PASS_OWN));
         end
      end

      for (int r = 0; r < N_ROWS; r++) begin
         run_row(r);
      end

      $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
verilog/xversat_pkg.sv
verilog/xstage_bus_if.sv
verilog/xalu_fu.sv
verilog/xstage_mem.sv
verilog/xiter_counter.sv
verilog/xrun_ctrl.sv
verilog/xstage.sv
verilog/xversat.sv
bench/xversat_tb.sv

/* Bender.yml */
package:
  name: xversat

sources:
  - verilog/xversat_pkg.sv
  - verilog/xstage_bus_if.sv
  - verilog/xalu_fu.sv
  - verilog/xstage_mem.sv
  - verilog/xiter_counter.sv
  - verilog/xrun_ctrl.sv
  - verilog/xstage.sv
  - verilog/xversat.sv
  - target: test
    files:
      - bench/xversat_tb.sv
